// File: Bender.yml
package:
  name: dadda_mul8

sources:
  - include_dirs:
      - logic
    files:
      - logic/dadda_pkg.sv
      - logic/kogge_stone_adder.sv
      - logic/dadda_tree_upper.sv
      - logic/dadda_tree_lower.sv
      - logic/dadda_mul8.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/dadda_mul8_tb.sv

// File: dadda_mul8.f
+incdir+logic
logic/dadda_pkg.sv
logic/kogge_stone_adder.sv
logic/dadda_tree_upper.sv
logic/dadda_tree_lower.sv
logic/dadda_mul8.sv
verif/dadda_mul8_tb.sv

// File: logic/dadda_defs.svh
// Dadda multiplier width definitions shared by the design
`ifndef DADDA_DEFS_SVH
`define DADDA_DEFS_SVH

// operand and product widths
`define DADDA_OP_WIDTH 8
`define DADDA_PROD_WIDTH 16

// one dot column per product bit
`define DADDA_COLS 16

// final adder spans columns 1 to 14
// its carry out becomes product bit 15
`define DADDA_FA_WIDTH 14

`endif

// File: logic/dadda_mul8.sv
// Unsigned 8x8 Dadda multiplier top level, fully combinational
`timescale 1ns/1ps
`default_nettype none

`include "dadda_defs.svh"

module dadda_mul8 (
    input  dadda_pkg::operand_t a,
    input  dadda_pkg::operand_t b,
    output dadda_pkg::product_t product
);
    import dadda_pkg::*;

    dot_rows4_t dot_rows;
    logic       pp_col0;
    addend_t    addend_x;
    addend_t    addend_y;
    addend_t    fa_sum;
    logic       fa_cout;

    dadda_tree_upper u_tree_upper (
        .a        (a),
        .b        (b),
        .dot_rows (dot_rows),
        .pp_col0  (pp_col0)
    );

    dadda_tree_lower u_tree_lower (
        .dot_rows (dot_rows),
        .addend_x (addend_x),
        .addend_y (addend_y)
    );

    kogge_stone_adder #(
        .width (`DADDA_FA_WIDTH)
    ) u_final_adder (
        .x    (addend_x),
        .y    (addend_y),
        .sum  (fa_sum),
        .cout (fa_cout)
    );

    // bit 0 is the lone column-0 dot, adder covers bits 1 to 15
    assign product = {fa_cout, fa_sum, pp_col0};

endmodule

`default_nettype wire

// File: logic/dadda_pkg.sv
// Dadda multiplier package with dot-matrix types and counter functions
`default_nettype none

`include "dadda_defs.svh"

package dadda_pkg;

    typedef logic [`DADDA_OP_WIDTH-1:0] operand_t;
    typedef logic [`DADDA_PROD_WIDTH-1:0] product_t;

    // row i is a ANDed with b[i], dot [i][j] sits in column i+j
    typedef logic [`DADDA_OP_WIDTH-1:0][`DADDA_OP_WIDTH-1:0] pp_matrix_t;

    // height-4 matrix, live dots packed into the low rows
    typedef logic [3:0][`DADDA_COLS-1:0] dot_rows4_t;

    typedef logic [`DADDA_FA_WIDTH-1:0] addend_t;

    // 3:2 counter, result is {carry, sum}
    function automatic logic [1:0] full_add(
        input logic x,
        input logic y,
        input logic z
    );
        logic sum;
        logic carry;
        sum = x ^ y ^ z;
        carry = (x & y) | (z & (x ^ y));
        return {carry, sum};
    endfunction

    // 2:2 counter, result is {carry, sum}
    function automatic logic [1:0] half_add(
        input logic x,
        input logic y
    );
        logic sum;
        logic carry;
        sum = x ^ y;
        carry = x & y;
        return {carry, sum};
    endfunction

endpackage

`default_nettype wire

// File: logic/dadda_tree_lower.sv
// Dadda tree back half: reduction from height 4 to 2 and final addend rows
`timescale 1ns/1ps
`default_nettype none

`include "dadda_defs.svh"

module dadda_tree_lower (
    input  dadda_pkg::dot_rows4_t dot_rows,
    output dadda_pkg::addend_t    addend_x,
    output dadda_pkg::addend_t    addend_y
);
    import dadda_pkg::*;

    logic [`DADDA_COLS-1:0] s2_sum;
    logic [`DADDA_COLS-1:0] s2_carry;
    logic [`DADDA_COLS-1:0] s3_sum;
    logic [`DADDA_COLS-1:0] s3_carry;

    // height-3 matrix between stage 2 and stage 3
    logic [2:0][`DADDA_COLS-1:0] rows3;

    // stage 2, height 4 to 3
    always_comb begin
        s2_sum = '0;
        s2_carry = '0;
        // column 3 has no carry coming in, so a half adder is enough
        {s2_carry[3], s2_sum[3]} = half_add(dot_rows[0][3], dot_rows[1][3]);
        for (int c = 4; c <= 12; c++) begin
            {s2_carry[c], s2_sum[c]} = full_add(dot_rows[0][c], dot_rows[1][c],
                                                dot_rows[2][c]);
        end
    end

    always_comb begin
        rows3 = '0;

        rows3[0][1] = dot_rows[0][1];
        rows3[1][1] = dot_rows[1][1];

        rows3[0][2] = dot_rows[0][2];
        rows3[1][2] = dot_rows[1][2];
        rows3[2][2] = dot_rows[2][2];

        rows3[0][3] = s2_sum[3];
        rows3[1][3] = dot_rows[2][3];
        rows3[2][3] = dot_rows[3][3];

        // sum, carry from the column below, untouched row 3 dot
        for (int c = 4; c <= 12; c++) begin
            rows3[0][c] = s2_sum[c];
            rows3[1][c] = s2_carry[c-1];
            rows3[2][c] = dot_rows[3][c];
        end

        rows3[0][13] = dot_rows[0][13];
        rows3[1][13] = dot_rows[1][13];
        rows3[2][13] = s2_carry[12];

        rows3[0][14] = dot_rows[0][14];
    end

    // stage 3, height 3 to 2 with a ripple of carries into the next column
    always_comb begin
        s3_sum = '0;
        s3_carry = '0;
        {s3_carry[2], s3_sum[2]} = half_add(rows3[0][2], rows3[1][2]);
        for (int c = 3; c <= 13; c++) begin
            {s3_carry[c], s3_sum[c]} = full_add(rows3[0][c], rows3[1][c], rows3[2][c]);
        end
    end

    // addend bit k carries column k+1
    always_comb begin
        addend_x = '0;
        addend_y = '0;

        addend_x[0] = rows3[0][1];
        addend_y[0] = rows3[1][1];

        addend_x[1] = s3_sum[2];
        addend_y[1] = rows3[2][2];

        for (int c = 3; c <= 13; c++) begin
            addend_x[c-1] = s3_carry[c-1];
            addend_y[c-1] = s3_sum[c];
        end

        addend_x[13] = s3_carry[13];
        addend_y[13] = rows3[0][14];
    end

endmodule

`default_nettype wire

// File: logic/dadda_tree_upper.sv
// Dadda tree front half: partial products and reduction from height 8 to 4
`timescale 1ns/1ps
`default_nettype none

`include "dadda_defs.svh"

module dadda_tree_upper (
    input  dadda_pkg::operand_t   a,
    input  dadda_pkg::operand_t   b,
    output dadda_pkg::dot_rows4_t dot_rows,
    output logic                  pp_col0
);
    import dadda_pkg::*;

    pp_matrix_t pp;

    // counter results, bit 0 is sum and bit 1 is carry
    logic [1:0] s0_c6;
    logic [1:0] s0_c7a, s0_c7b;
    logic [1:0] s0_c8a, s0_c8b;
    logic [1:0] s0_c9;
    logic [1:0] s1_c4;
    logic [1:0] s1_c5a, s1_c5b;
    logic [1:0] s1_c6a, s1_c6b;
    logic [1:0] s1_c7a, s1_c7b;
    logic [1:0] s1_c8a, s1_c8b;
    logic [1:0] s1_c9a, s1_c9b;
    logic [1:0] s1_c10a, s1_c10b;
    logic [1:0] s1_c11;

    always_comb begin
        for (int i = 0; i < `DADDA_OP_WIDTH; i++) begin
            pp[i] = a & {`DADDA_OP_WIDTH{b[i]}};
        end
    end

    // stage 0, height 8 to 6
    assign s0_c6  = half_add(pp[0][6], pp[1][5]);
    assign s0_c7a = full_add(pp[0][7], pp[1][6], pp[2][5]);
    assign s0_c7b = half_add(pp[3][4], pp[4][3]);
    assign s0_c8a = full_add(pp[1][7], pp[2][6], pp[3][5]);
    assign s0_c8b = half_add(pp[4][4], pp[5][3]);
    assign s0_c9  = full_add(pp[2][7], pp[3][6], pp[4][5]);

    // stage 1, height 6 to 4
    assign s1_c4   = half_add(pp[0][4], pp[1][3]);
    assign s1_c5a  = full_add(pp[0][5], pp[1][4], pp[2][3]);
    assign s1_c5b  = half_add(pp[3][2], pp[4][1]);
    assign s1_c6a  = full_add(s0_c6[0], pp[2][4], pp[3][3]);
    assign s1_c6b  = full_add(pp[4][2], pp[5][1], pp[6][0]);
    assign s1_c7a  = full_add(s0_c6[1], s0_c7a[0], s0_c7b[0]);
    assign s1_c7b  = full_add(pp[5][2], pp[6][1], pp[7][0]);
    assign s1_c8a  = full_add(s0_c7a[1], s0_c7b[1], s0_c8a[0]);
    assign s1_c8b  = full_add(s0_c8b[0], pp[6][2], pp[7][1]);
    assign s1_c9a  = full_add(s0_c8a[1], s0_c8b[1], s0_c9[0]);
    assign s1_c9b  = full_add(pp[5][4], pp[6][3], pp[7][2]);
    assign s1_c10a = full_add(s0_c9[1], pp[3][7], pp[4][6]);
    assign s1_c10b = full_add(pp[5][5], pp[6][4], pp[7][3]);
    assign s1_c11  = full_add(pp[4][7], pp[5][6], pp[6][5]);

    // column 0 bypasses the tree entirely
    assign pp_col0 = pp[0][0];

    // pack survivors, the lower tree expects its counter inputs in rows 0 to 2
    always_comb begin
        dot_rows = '0;

        dot_rows[0][1] = pp[0][1];
        dot_rows[1][1] = pp[1][0];

        dot_rows[0][2] = pp[0][2];
        dot_rows[1][2] = pp[1][1];
        dot_rows[2][2] = pp[2][0];

        dot_rows[0][3] = pp[0][3];
        dot_rows[1][3] = pp[1][2];
        dot_rows[2][3] = pp[2][1];
        dot_rows[3][3] = pp[3][0];

        dot_rows[0][4] = s1_c4[0];
        dot_rows[1][4] = pp[2][2];
        dot_rows[2][4] = pp[3][1];
        dot_rows[3][4] = pp[4][0];

        dot_rows[0][5] = s1_c4[1];
        dot_rows[1][5] = s1_c5a[0];
        dot_rows[2][5] = s1_c5b[0];
        dot_rows[3][5] = pp[5][0];

        // columns 6 to 10 hold two carries in and two sums
        dot_rows[0][6]  = s1_c5a[1];
        dot_rows[1][6]  = s1_c5b[1];
        dot_rows[2][6]  = s1_c6a[0];
        dot_rows[3][6]  = s1_c6b[0];
        dot_rows[0][7]  = s1_c6a[1];
        dot_rows[1][7]  = s1_c6b[1];
        dot_rows[2][7]  = s1_c7a[0];
        dot_rows[3][7]  = s1_c7b[0];
        dot_rows[0][8]  = s1_c7a[1];
        dot_rows[1][8]  = s1_c7b[1];
        dot_rows[2][8]  = s1_c8a[0];
        dot_rows[3][8]  = s1_c8b[0];
        dot_rows[0][9]  = s1_c8a[1];
        dot_rows[1][9]  = s1_c8b[1];
        dot_rows[2][9]  = s1_c9a[0];
        dot_rows[3][9]  = s1_c9b[0];
        dot_rows[0][10] = s1_c9a[1];
        dot_rows[1][10] = s1_c9b[1];
        dot_rows[2][10] = s1_c10a[0];
        dot_rows[3][10] = s1_c10b[0];

        dot_rows[0][11] = s1_c10a[1];
        dot_rows[1][11] = s1_c10b[1];
        dot_rows[2][11] = s1_c11[0];
        dot_rows[3][11] = pp[7][4];

        dot_rows[0][12] = s1_c11[1];
        dot_rows[1][12] = pp[5][7];
        dot_rows[2][12] = pp[6][6];
        dot_rows[3][12] = pp[7][5];

        dot_rows[0][13] = pp[6][7];
        dot_rows[1][13] = pp[7][6];

        dot_rows[0][14] = pp[7][7];
    end

endmodule

`default_nettype wire

// File: logic/kogge_stone_adder.sv
// Kogge-Stone parallel-prefix adder of configurable width
`timescale 1ns/1ps
`default_nettype none

`include "dadda_defs.svh"

module kogge_stone_adder #(
    parameter int width = `DADDA_FA_WIDTH
) (
    input  logic [width-1:0] x,
    input  logic [width-1:0] y,
    output logic [width-1:0] sum,
    output logic             cout
);

    localparam int levels = $clog2(width);

    // group generate and propagate, one row per prefix level
    logic [levels:0][width-1:0] g_lvl;
    logic [levels:0][width-1:0] p_lvl;
    logic [width-1:0]           carry;

    assign g_lvl[0] = x & y;
    assign p_lvl[0] = x ^ y;

    for (genvar l = 0; l < levels; l++) begin : g_level
        for (genvar k = 0; k < width; k++) begin : g_bit
            if (k >= (1 << l)) begin : g_merge
                assign g_lvl[l+1][k] = g_lvl[l][k] | (p_lvl[l][k] & g_lvl[l][k-(1<<l)]);
                assign p_lvl[l+1][k] = p_lvl[l][k] & p_lvl[l][k-(1<<l)];
            end else begin : g_pass
                // span already reaches bit 0
                assign g_lvl[l+1][k] = g_lvl[l][k];
                assign p_lvl[l+1][k] = p_lvl[l][k];
            end
        end
    end

    // carry into bit k is the group generate of bits k-1 down to 0
    assign carry[0] = 1'b0;
    for (genvar k = 1; k < width; k++) begin : g_carry
        assign carry[k] = g_lvl[levels][k-1];
    end

    assign sum  = p_lvl[0] ^ carry;
    assign cout = g_lvl[levels][width-1];

endmodule

`default_nettype wire

// File: verif/dadda_mul8_tb.sv
// Dadda multiplier testbench with directed and LFSR operand checks
`timescale 1ns/1ps
`default_nettype none

`include "dadda_defs.svh"

module dadda_mul8_tb;

    localparam int clk_period = 8;
    localparam int reset_cycles = 8;
    localparam int random_pairs = 2000;
    localparam int random_iter_limit = 4 * random_pairs;
    localparam logic [15:0] lfsr_seed = 16'd63753;
    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] lfsr_taps = 16'hB400;

    logic clk;
    logic reset;
    dadda_pkg::operand_t a;
    dadda_pkg::operand_t b;
    dadda_pkg::product_t product;

    logic [15:0] lfsr_state;
    int pairs_done;
    int iterations;

    dadda_mul8 u_dut (
        .a       (a),
        .b       (b),
        .product (product)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] nxt_state;
        nxt_state = state >> 1;
        if (state[0]) begin
            nxt_state = nxt_state ^ lfsr_taps;
        end
        return nxt_state;
    endfunction

    // one LFSR step per operand bit with msb first
    task automatic random_operand(output dadda_pkg::operand_t value);
        value = '0;
        for (int i = 0; i < `DADDA_OP_WIDTH; i++) begin
            value = {value[`DADDA_OP_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic value_mismatch(
        input string       name,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        $display("** Error at %0d ns: %s expected %0d (0x%04h), actual %0d (0x%04h)",
                 $time, name, expected, expected, actual, actual);
        report_failure("product check failed");
    endtask

    // called right after a rising edge and sampled at the next one
    task automatic apply_operands(
        input  dadda_pkg::operand_t op_a,
        input  dadda_pkg::operand_t op_b,
        output dadda_pkg::product_t seen
    );
        a <= op_a;
        b <= op_b;
        @(posedge clk);
        seen = product;
    endtask

    task automatic apply_and_check(
        input  dadda_pkg::operand_t op_a,
        input  dadda_pkg::operand_t op_b,
        output dadda_pkg::product_t seen
    );
        logic [15:0] expected;
        expected = {8'h00, op_a} * {8'h00, op_b};
        apply_operands(op_a, op_b, seen);
        assert (seen === expected)
            else value_mismatch("product", expected, seen);
    endtask

    // operands are held at zero while reset is high
    always @(posedge clk) begin
        if (reset) begin
            assert (product === '0)
                else value_mismatch("product", '0, product);
        end
    end

    initial begin
        dadda_pkg::operand_t op_a;
        dadda_pkg::operand_t op_b;
        dadda_pkg::product_t first;
        dadda_pkg::product_t second;

        a = '0;
        b = '0;
        reset = 1'b1;
        lfsr_state = lfsr_seed;
        pairs_done = 0;
        iterations = 0;

        for (int n = 0; n < reset_cycles; n++) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        // zero on either side
        for (int v = 0; v < 256; v++) begin
            apply_and_check('0, dadda_pkg::operand_t'(v), first);
            apply_and_check(dadda_pkg::operand_t'(v), '0, first);
        end

        // identity
        for (int v = 0; v < 256; v++) begin
            apply_and_check(8'd1, dadda_pkg::operand_t'(v), first);
            apply_and_check(dadda_pkg::operand_t'(v), 8'd1, first);
        end

        // walking ones give one dot per column
        for (int i = 0; i < `DADDA_OP_WIDTH; i++) begin
            for (int j = 0; j < `DADDA_OP_WIDTH; j++) begin
                op_a = dadda_pkg::operand_t'(1) << i;
                op_b = dadda_pkg::operand_t'(1) << j;
                apply_and_check(op_a, op_b, first);
            end
        end

        // full tree height and carry into bit 15
        apply_and_check(8'hFF, 8'hFF, first);

        while (pairs_done < random_pairs && iterations < random_iter_limit) begin
            random_operand(op_a);
            random_operand(op_b);
            apply_and_check(op_a, op_b, first);
            apply_operands(op_b, op_a, second);
            assert (second === first)
                else value_mismatch("product", first, second);
            pairs_done++;
            iterations++;
        end

        if (pairs_done != random_pairs) begin
            report_failure("random stimulus did not complete within its iteration bound");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
